/* rtl/cpu_pkg.sv */
// Shared types for the 16-bit bus datapath; code 7 is spare on both source and destination fields
package cpu_pkg;

    typedef logic [15:0] word_t;    // Bus and register word
    typedef logic [15:0] uinstr_t;  // Microinstruction word
    typedef logic [2:0]  bus_sel_t; // Bus source or destination field

    // Bus source codes, valid when EO is clear
    localparam bus_sel_t SRC_PC  = 3'd0;
    localparam bus_sel_t SRC_IOH = 3'd1; // IR upper byte
    localparam bus_sel_t SRC_IOL = 3'd2; // IR lower byte
    localparam bus_sel_t SRC_RAM = 3'd3;
    localparam bus_sel_t SRC_X   = 3'd4;
    localparam bus_sel_t SRC_Y   = 3'd5;
    localparam bus_sel_t SRC_DEV = 3'd6;

    // Bus destination codes
    localparam bus_sel_t DST_NONE = 3'd0; // Nobody loads
    localparam bus_sel_t DST_MAR  = 3'd1;
    localparam bus_sel_t DST_IR   = 3'd2;
    localparam bus_sel_t DST_RAM  = 3'd3;
    localparam bus_sel_t DST_X    = 3'd4;
    localparam bus_sel_t DST_Y    = 3'd5;
    localparam bus_sel_t DST_DEV  = 3'd6;

    // ALU controls, same order as microinstruction bits 14..9
    typedef struct packed {
        logic ex; // Use X, else zero
        logic nx; // Invert X operand
        logic ey; // Use Y, else zero
        logic ny; // Invert Y operand
        logic f;  // Add, else AND
        logic no; // Invert result
    } alu_fn_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic gt;
        logic lt;
    } flags_t;

    typedef struct packed {
        logic pc, ioh, iol, ram, x, y, dev;
    } out_en_t; // One-hot bus sources

    typedef struct packed {
        logic mar, ir, ram, x, y, dev;
    } in_en_t; // One-hot bus destinations

    typedef struct packed {
        logic jc, jz, jgt, jlt;
    } jmp_t; // Jump conditions, microinstruction bits 5..2

    // Decoder output, 26 bits
    typedef struct packed {
        logic    eo;     // ALU drives the bus
        out_en_t out_en;
        in_en_t  in_en;
        logic    rt;     // Microsequence reset request
        logic    pa;     // PC increment
        alu_fn_t alu_fn;
        jmp_t    jmp;
    } ctrl_t;

endpackage

/* rtl/control_decode.sv */
// Purely combinational; ctrl is all zero while uinstr_strobe is low, bits 1..0 of the word are ignored
`timescale 1ns/100ps

module control_decode (
    input  cpu_pkg::uinstr_t uinstr,
    input  logic             uinstr_strobe,
    output cpu_pkg::ctrl_t   ctrl
);
    import cpu_pkg::*;

    logic     eo_bit;  // Bit 15
    bus_sel_t src_sel; // Bits 14..12 when EO clear
    bus_sel_t dst_sel; // Bits 8..6, always a destination

    assign eo_bit  = uinstr[15];
    assign src_sel = uinstr[14:12];
    assign dst_sel = uinstr[8:6];

    always_comb begin
        ctrl = '0; // Idle cycle, nothing moves
        if (uinstr_strobe) begin
            ctrl.eo  = eo_bit;
            ctrl.jmp = uinstr[5:2]; // Jumps allowed in either cycle type
            if (eo_bit) begin
                ctrl.alu_fn = uinstr[14:9]; // Bits 14..9 are ALU controls
            end else begin
                ctrl.rt = uinstr[11];
                ctrl.pa = uinstr[10];
                case (src_sel)
                    SRC_PC:  ctrl.out_en.pc  = 1'b1;
                    SRC_IOH: ctrl.out_en.ioh = 1'b1;
                    SRC_IOL: ctrl.out_en.iol = 1'b1;
                    SRC_RAM: ctrl.out_en.ram = 1'b1;
                    SRC_X:   ctrl.out_en.x   = 1'b1;
                    SRC_Y:   ctrl.out_en.y   = 1'b1;
                    SRC_DEV: ctrl.out_en.dev = 1'b1;
                    default: ; // Spare source, bus stays zero
                endcase
            end
            case (dst_sel)
                DST_NONE: ;
                DST_MAR:  ctrl.in_en.mar = 1'b1;
                DST_IR:   ctrl.in_en.ir  = 1'b1;
                DST_RAM:  ctrl.in_en.ram = 1'b1;
                DST_X:    ctrl.in_en.x   = 1'b1;
                DST_Y:    ctrl.in_en.y   = 1'b1;
                DST_DEV:  ctrl.in_en.dev = 1'b1;
                default:  ; // Spare destination
            endcase
        end
    end

    // Deferred so that a strobe edge does not race the decode
    always_comb begin
        a_out_onehot: assert final ($onehot0(ctrl.out_en))
            else $error("control_decode: more than one bus source");
        a_no_src_with_eo: assert final (!(ctrl.eo && (ctrl.out_en != '0)))
            else $error("control_decode: bus source enabled in ALU cycle");
        a_idle_zero: assert final (uinstr_strobe || (ctrl == '0))
            else $error("control_decode: control active without strobe");
    end

endmodule

/* rtl/alu.sv */
// Combinational ALU; carry is valid only for add, AND leaves it zero
`timescale 1ns/100ps

module alu (
    input  cpu_pkg::word_t  x,
    input  cpu_pkg::word_t  y,
    input  cpu_pkg::alu_fn_t fn,
    output cpu_pkg::word_t  result,
    output cpu_pkg::flags_t flags_next
);
    import cpu_pkg::*;

    word_t x_zeroed, y_zeroed; // After enable stage
    word_t x_op, y_op;         // After invert stage
    word_t raw;                // Before output invert
    logic  carry;

    always_comb begin
        x_zeroed = fn.ex ? x : '0;
        y_zeroed = fn.ey ? y : '0;
        x_op     = fn.nx ? ~x_zeroed : x_zeroed;
        y_op     = fn.ny ? ~y_zeroed : y_zeroed;
        if (fn.f) begin
            {carry, raw} = {1'b0, x_op} + {1'b0, y_op}; // 17-bit sum
        end else begin
            raw   = x_op & y_op;
            carry = 1'b0;
        end
        result = fn.no ? ~raw : raw; // nx+no gives X minus Y
    end

    // Flags follow the final result
    always_comb begin
        flags_next.carry = carry;
        flags_next.zero  = (result == '0);
        flags_next.lt    = result[15]; // Signed negative
        flags_next.gt    = !flags_next.zero && !flags_next.lt;
    end

endmodule

/* rtl/reg_bus.sv */
// Registers and bus mux; RAM_ADDR_BITS must not exceed 16, MAR takes the low bus bits
`timescale 1ns/100ps

module reg_bus #(
    parameter int RAM_ADDR_BITS = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_pkg::ctrl_t           ctrl,
    input  cpu_pkg::word_t           alu_result,
    input  cpu_pkg::flags_t          alu_flags,
    input  cpu_pkg::word_t           ram_q,
    input  cpu_pkg::word_t           dev_in,
    output cpu_pkg::word_t           x,
    output cpu_pkg::word_t           y,
    output logic [RAM_ADDR_BITS-1:0] mar,
    output cpu_pkg::word_t           bus,
    output cpu_pkg::word_t           dev_out,
    output logic                     dev_out_strobe
);
    import cpu_pkg::*;

    typedef logic [RAM_ADDR_BITS-1:0] addr_t;

    word_t  pc;
    word_t  ir;
    flags_t flags;    // Written by the last ALU cycle
    logic   jump_take;

    // Bus mux, out_en is one-hot or zero
    always_comb begin
        bus = '0;
        if (ctrl.eo) begin
            bus = alu_result;
        end else begin
            if (ctrl.out_en.pc)  bus = pc;
            if (ctrl.out_en.ioh) bus = {8'h00, ir[15:8]}; // Zero-extended
            if (ctrl.out_en.iol) bus = {8'h00, ir[7:0]};
            if (ctrl.out_en.ram) bus = ram_q;
            if (ctrl.out_en.x)   bus = x;
            if (ctrl.out_en.y)   bus = y;
            if (ctrl.out_en.dev) bus = dev_in;
        end
    end

    // Conditions test flags as they stood before this edge
    assign jump_take = (ctrl.jmp.jc  && flags.carry) ||
                       (ctrl.jmp.jz  && flags.zero)  ||
                       (ctrl.jmp.jgt && flags.gt)    ||
                       (ctrl.jmp.jlt && flags.lt);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc             <= '0;
            ir             <= '0;
            mar            <= '0;
            x              <= '0;
            y              <= '0;
            flags          <= '0;
            dev_out        <= '0;
            dev_out_strobe <= 1'b0;
        end else begin
            if (jump_take)       pc <= bus;      // Jump wins over P+
            else if (ctrl.pa)    pc <= pc + 1'b1;
            if (ctrl.in_en.ir)   ir <= bus;
            if (ctrl.in_en.mar)  mar <= addr_t'(bus);
            if (ctrl.in_en.x)    x <= bus;
            if (ctrl.in_en.y)    y <= bus;
            if (ctrl.eo)         flags <= alu_flags;
            if (ctrl.in_en.dev)  dev_out <= bus;
            dev_out_strobe <= ctrl.in_en.dev; // Pulse for the cycle after the load
        end
    end

    // Back-to-back strobes only from back-to-back device loads
    a_strobe_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        dev_out_strobe && $past(dev_out_strobe)
            |-> $past(ctrl.in_en.dev) && $past(ctrl.in_en.dev, 2))
        else $error("reg_bus: dev_out_strobe held without device loads");

endmodule

/* rtl/ram_block.sv */
// Single-port RAM, no reset so contents are undefined until written; read is asynchronous
`timescale 1ns/100ps

module ram_block #(
    parameter int RAM_ADDR_BITS = 8
) (
    input  logic                     clk,
    input  logic [RAM_ADDR_BITS-1:0] addr,
    input  cpu_pkg::word_t           wdata,
    input  logic                     we,
    output cpu_pkg::word_t           q
);
    import cpu_pkg::*;

    localparam int DEPTH = 2 ** RAM_ADDR_BITS;

    word_t mem [DEPTH]; // Word array, one entry per MAR value

    // Write at the edge ending the RAM-destination cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    assign q = mem[addr]; // Combinational read, same cycle as the source enable

endmodule

/* rtl/cpu_top.sv */
// Datapath top; microinstructions come from outside, RT is only reported on uop_reset
`timescale 1ns/100ps

module cpu_top #(
    parameter int RAM_ADDR_BITS = 8 // MAR and RAM address width, at most 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  cpu_pkg::uinstr_t uinstr,
    input  logic             uinstr_strobe,
    input  cpu_pkg::word_t   dev_in,
    output cpu_pkg::word_t   dev_out,
    output logic             dev_out_strobe,
    output logic             uop_reset
);
    import cpu_pkg::*;

    ctrl_t                    ctrl;
    word_t                    bus;
    word_t                    x_op, y_op; // Operands from X and Y
    word_t                    alu_result;
    flags_t                   flags_next;
    word_t                    ram_q;
    logic [RAM_ADDR_BITS-1:0] mar;

    control_decode u_decode (
        .uinstr        (uinstr),
        .uinstr_strobe (uinstr_strobe),
        .ctrl          (ctrl)
    );

    alu u_alu (
        .x          (x_op),
        .y          (y_op),
        .fn         (ctrl.alu_fn),
        .result     (alu_result),
        .flags_next (flags_next)
    );

    reg_bus #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl           (ctrl),
        .alu_result     (alu_result),
        .alu_flags      (flags_next),
        .ram_q          (ram_q),
        .dev_in         (dev_in),
        .x              (x_op),
        .y              (y_op),
        .mar            (mar),
        .bus            (bus),
        .dev_out        (dev_out),
        .dev_out_strobe (dev_out_strobe)
    );

    ram_block #(.RAM_ADDR_BITS(RAM_ADDR_BITS)) u_ram (
        .clk   (clk),
        .addr  (mar),
        .wdata (bus),
        .we    (ctrl.in_en.ram), // RAM destination selected
        .q     (ram_q)
    );

    assign uop_reset = ctrl.rt; // Already cleared by EO in the decoder

endmodule

/* sim/tb_clock.sv */
// Free-running clock from time zero, starts low, first rising edge after half a period
`timescale 1ns/100ps

module tb_clock #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk; // 2 ns half period
    end

endmodule

/* sim/tb_checker.sv */
// Each case is held from one falling edge to the next; registered outputs are checked a cycle later
`timescale 1ns/100ps

module tb_checker (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           case_valid,
    input  logic [7:0]     case_id,
    input  logic           case_last,
    input  logic           exp_dev_chk,
    input  cpu_pkg::word_t exp_dev,
    input  logic           exp_strobe,
    input  logic           exp_rt,
    input  cpu_pkg::word_t dev_out,
    input  logic           dev_out_strobe,
    input  logic           uop_reset,
    output int             tests_pass,
    output int             tests_fail,
    output int             err_count
);
    import cpu_pkg::*;

    logic       pend = 1'b0; // Case waiting for its falling-edge check
    logic       pend_last, pend_chk, pend_strobe, pend_rt;
    logic       rt_seen;     // uop_reset as sampled mid-case
    logic [7:0] pend_id;
    word_t      pend_dev;
    time        rt_time;
    int         n_pass = 0;
    int         n_fail = 0;
    int         n_err = 0;
    int         test_errs = 0;

    assign tests_pass = n_pass;
    assign tests_fail = n_fail;
    assign err_count  = n_err;

    // Case and decoder output are both settled here
    always @(posedge clk) begin
        pend        = case_valid && rst_n;
        pend_id     = case_id;
        pend_last   = case_last;
        pend_chk    = exp_dev_chk;
        pend_dev    = exp_dev;
        pend_strobe = exp_strobe;
        pend_rt     = exp_rt;
        rt_seen     = uop_reset;
        rt_time     = $time;
    end

    task automatic count_error();
        n_err++;
        test_errs++;
    endtask

    always @(negedge clk) begin
        if (pend) begin
            if (rt_seen !== pend_rt) begin
                $display("FAILED t=%0t uop_reset expected %b actual %b", rt_time, pend_rt, rt_seen);
                count_error();
            end
            if (pend_chk && dev_out !== pend_dev) begin
                $display("FAILED t=%0t dev_out expected %h actual %h", $time, pend_dev, dev_out);
                count_error();
            end
            if (pend_strobe && dev_out_strobe !== 1'b1) begin
                $display("FAILED t=%0t dev_out_strobe expected 1 actual %b", $time, dev_out_strobe);
                count_error();
            end else if (!pend_strobe && dev_out_strobe !== 1'b0) begin
                $display("Test %0d: dev_out_strobe pulsed at %0t with no device load expected",
                         pend_id, $time);
                count_error();
            end
            if (pend_last) begin
                if (test_errs == 0) begin
                    $display("Test %0d passed", pend_id);
                    n_pass++;
                end else begin
                    $display("Test %0d failed with %0d errors", pend_id, test_errs);
                    n_fail++;
                end
                test_errs = 0;
            end
        end else if (rst_n && dev_out_strobe) begin
            $display("dev_out_strobe pulsed at %0t while no case was running", $time);
            n_err++;
        end
    end

endmodule

/* sim/tb_top.sv */
// Case-driven testbench; run from the project root, at most 64 cases, case ids fit in 8 bits
`timescale 1ns/100ps

module tb_top;
    import cpu_pkg::*;

    localparam int          MAX_CASES = 64;
    localparam int          COLS      = 5;         // Columns per case line
    localparam logic [19:0] MARK      = 20'hfffff; // Idle line or unchecked dev_out
    localparam uinstr_t     IDLE_WORD = 16'h6180;  // Device in to device out, ignored while idle

    logic        clk;
    logic        rst_n;
    uinstr_t     uinstr;
    logic        uinstr_strobe;
    word_t       dev_in;
    word_t       dev_out;
    logic        dev_out_strobe;
    logic        uop_reset;

    // Expected values handed to the checker
    logic        case_valid;
    logic        case_last;
    logic [7:0]  case_id;
    logic        exp_dev_chk;
    word_t       exp_dev;
    logic        exp_strobe;
    logic        exp_rt;
    int          tests_pass;
    int          tests_fail;
    int          err_count;

    logic [19:0] cases [MAX_CASES*COLS];
    int          num_cases;
    int          cycle_count = 0;
    int          cycle_limit = 8;

    tb_clock u_clock (.clk(clk));

    cpu_top #(.RAM_ADDR_BITS(8)) UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .uinstr         (uinstr),
        .uinstr_strobe  (uinstr_strobe),
        .dev_in         (dev_in),
        .dev_out        (dev_out),
        .dev_out_strobe (dev_out_strobe),
        .uop_reset      (uop_reset)
    );

    tb_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .case_valid     (case_valid),
        .case_id        (case_id),
        .case_last      (case_last),
        .exp_dev_chk    (exp_dev_chk),
        .exp_dev        (exp_dev),
        .exp_strobe     (exp_strobe),
        .exp_rt         (exp_rt),
        .dev_out        (dev_out),
        .dev_out_strobe (dev_out_strobe),
        .uop_reset      (uop_reset),
        .tests_pass     (tests_pass),
        .tests_fail     (tests_fail),
        .err_count      (err_count)
    );

    // One case line onto the DUT inputs and the checker
    task automatic drive_case(input int k);
        logic [19:0] op;
        logic [19:0] expd;
        op            = cases[k*COLS+1];
        expd          = cases[k*COLS+3];
        case_id       = cases[k*COLS][7:0];
        uinstr_strobe = (op != MARK);            // Idle line keeps the strobe low
        uinstr        = uinstr_strobe ? op[15:0] : IDLE_WORD;
        dev_in        = cases[k*COLS+2][15:0];
        exp_dev_chk   = (expd != MARK);
        exp_dev       = expd[15:0];
        exp_strobe    = exp_dev_chk && uinstr_strobe; // Checked value on a strobed line is a load
        exp_rt        = cases[k*COLS+4][0];
        case_last     = (k == num_cases - 1) || (cases[(k+1)*COLS] != cases[k*COLS]);
        case_valid    = 1'b1;
    endtask

    // Run limit grows with the case count
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_limit);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        rst_n         = 1'b0;
        uinstr        = '0;
        uinstr_strobe = 1'b0;
        dev_in        = '0;
        case_valid    = 1'b0;
        case_last     = 1'b0;
        case_id       = '0;
        exp_dev_chk   = 1'b0;
        exp_dev       = '0;
        exp_strobe    = 1'b0;
        exp_rt        = 1'b0;
        for (int i = 0; i < MAX_CASES * COLS; i++) begin
            cases[i] = MARK; // Unfilled entries end the list
        end
        $readmemh("sim/uinstr_cases.txt", cases);
        num_cases = 0;
        while (num_cases < MAX_CASES && cases[num_cases*COLS] != MARK) begin
            num_cases++;
        end
        cycle_limit = 8 + 4 * num_cases;
        repeat (8) @(posedge clk); // Reset held 8 cycles
        @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < num_cases; k++) begin
            @(negedge clk);
            drive_case(k);
        end
        @(negedge clk);
        uinstr_strobe = 1'b0;
        uinstr        = '0;
        case_valid    = 1'b0;
        @(posedge clk); // Checker done with the last case
        $display("Tests passed %0d, failed %0d, check errors %0d",
                 tests_pass, tests_fail, err_count);
        if (err_count == 0 && tests_fail == 0 && tests_pass > 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* sim/uinstr_cases.txt */
// Columns: test id, microinstruction (fffff = idle, strobe low), dev_in,
// expected dev_out (fffff = not checked, a value on a strobed line is a device load), uop_reset
1 6100 1234 fffff 0
1 4180 0000 1234 0
1 6140 beef fffff 0
1 5180 0000 beef 0
2 6100 0009 fffff 0
2 6140 0003 fffff 0
2 d580 0000 000c 0
2 d180 0000 0001 0
2 f780 0000 0006 0
2 a580 0000 ffff 0
2 af80 0000 0001 0
3 8400 0000 fffff 0
3 6410 0040 fffff 0
3 0180 0000 0040 0
3 6404 0100 fffff 0
3 0180 0000 0041 0
3 a500 0000 fffff 0
3 6404 0200 fffff 0
3 0180 0000 0200 0
4 6040 0005 fffff 0
4 60c0 aaaa fffff 0
4 6040 0006 fffff 0
4 60c0 5555 fffff 0
4 3180 0000 5555 0
4 6040 0005 fffff 0
4 3180 0000 aaaa 0
5 fffff 1111 aaaa 0
5 fffff 2222 aaaa 0
5 4800 0000 fffff 1
5 8800 0000 fffff 0
5 8400 0000 fffff 0
5 0180 0000 0200 0
5 0580 0000 0200 0
5 0180 0000 0201 0

/* src.f */
rtl/cpu_pkg.sv
rtl/control_decode.sv
rtl/alu.sv
rtl/reg_bus.sv
rtl/ram_block.sv
rtl/cpu_top.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" && rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_top > build.log 2>&1 &&
./obj_dir/Vtb_top > sim.log 2>&1
grep -qx "Everything OK" sim.log && echo "PASS" || { echo "FAIL, see build.log and sim.log"; exit 1; }
